//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= timer_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+verilog
verilog/timer_cfg_pkg.sv
verilog/timer_evt_pkg.sv
verilog/event_select.sv
verilog/count_core.sv
verilog/waveform_gen.sv
verilog/capture_bank.sv
verilog/irq_gen.sv
verilog/timer_top.sv
sim/timer_tb.sv

//--- sim/timer_tb.sv
`timescale 1ns/1ps
`include "timer_settings.svh"

module timer_tb;

    localparam int W = `TMR_COUNT_W;
    localparam int N = `TMR_CAP_N;
    localparam int MAX_CYCLES = 2000;  // longest sequence is well under 400 cycles.
    localparam int STATE_W = 2 + 3 + 2 * N + W;
    localparam logic [STATE_W-1:0] RESET_STATE = {2'b11, {(STATE_W - 2){1'b0}}};

    logic                                 i_clk;
    logic                                 i_rst_n;
    logic                                 i_enable;
    logic                                 i_ext_din_a;
    logic                                 i_ext_din_b;
    logic [`TMR_INNER_N-1:0]              i_inner_din;
    logic                                 i_soft_start;
    logic                                 i_soft_stop;
    logic                                 i_soft_clear;
    timer_cfg_pkg::mode_t                 i_mode;
    timer_cfg_pkg::src_cfg_t              i_src;
    timer_cfg_pkg::wave_chan_t            i_wave_a;
    timer_cfg_pkg::wave_chan_t            i_wave_b;
    timer_cfg_pkg::cap_cfg_t              i_cap_cfg;
    timer_evt_pkg::cap_status_t           i_read_flag;
    logic                                 o_dout_a;
    logic                                 o_dout_b;
    logic                                 o_dout_a_oen;
    logic                                 o_dout_b_oen;
    logic [W-1:0]                         o_count;
    logic [N-1:0][W-1:0]                  o_cap_a;
    logic [N-1:0][W-1:0]                  o_cap_b;
    timer_evt_pkg::cap_status_t           o_cap_status;
    timer_evt_pkg::irq_t                  o_irq;

    int                  cyc;
    int                  mismatch_cnt;
    int                  fail_cnt;
    int                  full_pulses;
    int                  start_cyc;
    int                  cap_idx;
    logic [7:0]          lfsr;
    logic                post_reset;
    logic                count_chk;
    logic                frozen_chk;
    logic                wave_chk;
    logic                cap_cmp;
    logic [W-1:0]        cnt_q;
    logic [W-1:0]        cnt_qq;
    logic                dout_q;
    logic                full_q;
    logic                full_qq;
    logic                clr_q;
    logic                stop_q;
    logic [N-1:0][W-1:0] exp_cap;  // capture model, channel a.
    logic [N-1:0]        exp_sts;
    logic [W-1:0]        exp_count;
    logic                exp_dout;
    logic                exp_period;
    logic                exp_full;

    timer_top timer_top_i (.*);

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // 8-bit fibonacci lfsr, taps 8 6 5 4.
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // history of the outputs, one and two cycles back.
    always @(posedge i_clk) begin
        cyc     <= cyc + 1;
        cnt_q   <= o_count;
        cnt_qq  <= cnt_q;
        dout_q  <= o_dout_a;
        full_q  <= &o_cap_status.a;
        full_qq <= full_q;
        clr_q   <= i_soft_clear;
        stop_q  <= i_soft_stop;
        if (i_rst_n && o_irq.cap_a_full) begin
            full_pulses <= full_pulses + 1;
        end
    end

    always_comb begin
        if (cnt_q != i_wave_a.t2) begin
            exp_count = cnt_q + W'(1);
        end else if (i_wave_a.halt) begin
            exp_count = cnt_q;  // halted at the period end.
        end else begin
            exp_count = '0;
        end
        if (cnt_q == i_wave_a.t0) begin
            exp_dout = 1'b0;
        end else if (cnt_q == i_wave_a.t1) begin
            exp_dout = 1'b1;
        end else if (cnt_q == i_wave_a.t2) begin
            exp_dout = i_wave_a.idle_level;
        end else begin
            exp_dout = dout_q;
        end
        exp_period = (cnt_q == i_wave_a.t2) && (cnt_qq != i_wave_a.t2);
        exp_full   = full_q && !full_qq;
    end

    task automatic print_counts();
        $display("summary: %0d mismatches, %0d other errors in %0d cycles",
                 mismatch_cnt, fail_cnt, cyc);
    endtask

    always @(posedge i_clk) begin
        if (cyc >= MAX_CYCLES) begin
            fail_cnt = fail_cnt + 1;
            $display("timeout at %0t, the sequence did not finish in %0d cycles",
                     $time, MAX_CYCLES);
            print_counts();
            $display("Some tests failed");
            $finish;
        end
    end

    a_reset_state: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        post_reset |-> {o_dout_a_oen, o_dout_b_oen, o_irq, o_cap_status, o_count} == RESET_STATE)
    else begin
        mismatch_cnt = mismatch_cnt + 1;
        $display("Mismatch at %0t: reset outputs expected %h got %h", $time, RESET_STATE,
                 $sampled({o_dout_a_oen, o_dout_b_oen, o_irq, o_cap_status, o_count}));
    end

    a_count_step: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        count_chk |-> o_count == cnt_q + W'(1))
    else begin
        mismatch_cnt = mismatch_cnt + 1;
        $display("Mismatch at %0t: o_count expected %0d got %0d", $time,
                 $sampled(cnt_q) + W'(1), $sampled(o_count));
    end

    a_count_frozen: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        frozen_chk |-> o_count == cnt_q)
    else begin
        mismatch_cnt = mismatch_cnt + 1;
        $display("Mismatch at %0t: o_count expected %0d got %0d", $time,
                 $sampled(cnt_q), $sampled(o_count));
    end

    a_count_clear: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        clr_q |-> o_count == '0)
    else begin
        mismatch_cnt = mismatch_cnt + 1;
        $display("Mismatch at %0t: o_count expected 0 got %0d", $time, $sampled(o_count));
    end

    a_cap_clear: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        clr_q |-> {o_cap_status, o_cap_a, o_cap_b} == '0)
    else begin
        mismatch_cnt = mismatch_cnt + 1;
        $display("Mismatch at %0t: capture state expected 0 got %h", $time,
                 $sampled({o_cap_status, o_cap_a, o_cap_b}));
    end

    a_stop_oen: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        stop_q |-> o_dout_a_oen && o_dout_b_oen)
    else begin
        mismatch_cnt = mismatch_cnt + 1;
        $display("Mismatch at %0t: o_dout_a_oen/o_dout_b_oen expected 11 got %b%b", $time,
                 $sampled(o_dout_a_oen), $sampled(o_dout_b_oen));
    end

    a_wave_count: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        wave_chk |-> o_count == exp_count)
    else begin
        mismatch_cnt = mismatch_cnt + 1;
        $display("Mismatch at %0t: o_count expected %0d got %0d", $time,
                 $sampled(exp_count), $sampled(o_count));
    end

    // both pins share the same targets.
    a_wave_dout: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        wave_chk |-> {o_dout_a, o_dout_a_oen, o_dout_b, o_dout_b_oen} ==
                     {exp_dout, 1'b0, exp_dout, 1'b0})
    else begin
        mismatch_cnt = mismatch_cnt + 1;
        $display("Mismatch at %0t: o_dout_a/o_dout_a_oen/o_dout_b/o_dout_b_oen %s %b0%b0 %s %b%b%b%b",
                 $time, "expected", $sampled(exp_dout), $sampled(exp_dout), "got",
                 $sampled(o_dout_a), $sampled(o_dout_a_oen),
                 $sampled(o_dout_b), $sampled(o_dout_b_oen));
    end

    a_period_irq: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        wave_chk |-> o_irq.period_hit == exp_period)
    else begin
        mismatch_cnt = mismatch_cnt + 1;
        $display("Mismatch at %0t: o_irq.period_hit expected %b got %b", $time,
                 $sampled(exp_period), $sampled(o_irq.period_hit));
    end

    a_full_irq: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_irq.cap_a_full == exp_full)
    else begin
        mismatch_cnt = mismatch_cnt + 1;
        $display("Mismatch at %0t: o_irq.cap_a_full expected %b got %b", $time,
                 $sampled(exp_full), $sampled(o_irq.cap_a_full));
    end

    for (genvar k = 0; k < N; k++) begin : g_cap_chk
        a_cap_value: assert property (@(posedge i_clk) disable iff (!i_rst_n)
            cap_cmp |-> o_cap_a[k] == exp_cap[k])
        else begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("Mismatch at %0t: o_cap_a[%0d] expected %0d got %0d", $time, k,
                     $sampled(exp_cap[k]), $sampled(o_cap_a[k]));
        end
    end

    a_cap_status: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        cap_cmp |-> {o_cap_status.b, o_cap_status.a} == {{N{1'b0}}, exp_sts})
    else begin
        mismatch_cnt = mismatch_cnt + 1;
        $display("Mismatch at %0t: o_cap_status expected %b got %b", $time,
                 {{N{1'b0}}, $sampled(exp_sts)}, $sampled(o_cap_status));
    end

    // returns 5 ns after the n-th rising edge.
    task automatic next_cycles(input int n);
        repeat (n) @(posedge i_clk);
        #5;
    endtask

    task automatic soft_strobe(input logic start, input logic stop, input logic clear);
        i_soft_start = start;
        i_soft_stop  = stop;
        i_soft_clear = clear;
        next_cycles(1);
        i_soft_start = 1'b0;
        i_soft_stop  = 1'b0;
        i_soft_clear = 1'b0;
    endtask

    task automatic wait_count(input logic [W-1:0] value);
        do begin
            next_cycles(1);
        end while (o_count != value);
    endtask

    task automatic pick_targets(input logic halt);
        i_wave_a.t0         = W'(1 + rand_bits(3));
        i_wave_a.t1         = i_wave_a.t0 + W'(1 + rand_bits(3));
        i_wave_a.t2         = i_wave_a.t1 + W'(1 + rand_bits(3));
        i_wave_a.keep       = 1'b0;
        i_wave_a.halt       = halt;
        i_wave_a.idle_level = rand_bits(1) != 0;
        i_wave_b            = i_wave_a;  // same period on both pins.
    endtask

    task automatic compare_capture();
        cap_cmp = 1'b1;
        next_cycles(1);
        cap_cmp = 1'b0;
    endtask

    // one rising edge on ext b, then a random gap.
    task automatic capture_edge();
        int slot;
        slot = cap_idx;
        i_ext_din_b = 1'b1;
        if (!exp_sts[slot] || i_cap_cfg.ovw_a[slot]) begin
            exp_cap[slot] = W'(cyc - start_cyc + 1);  // count three edges later.
            exp_sts[slot] = 1'b1;
        end
        cap_idx = (cap_idx + 1) % N;
        next_cycles(1);
        i_ext_din_b = 1'b0;
        next_cycles(4 + rand_bits(2));
        compare_capture();
    endtask

    initial begin
        i_rst_n      = 1'b0;
        i_enable     = 1'b1;
        i_ext_din_a  = 1'b0;
        i_ext_din_b  = 1'b0;
        i_inner_din  = '0;
        i_soft_start = 1'b0;
        i_soft_stop  = 1'b0;
        i_soft_clear = 1'b0;
        i_mode       = timer_cfg_pkg::CAPTURE;
        i_src.start  = '{sel: '0, edg: `TMR_EDGE_RISE};
        i_src.stop   = '{sel: '1, edg: `TMR_EDGE_NONE};
        i_src.din0   = '{sel: `TMR_SEL_W'(1), edg: `TMR_EDGE_RISE};
        i_src.din1   = '{sel: '1, edg: `TMR_EDGE_NONE};
        i_wave_a     = '0;
        i_wave_b     = '0;
        i_cap_cfg    = '0;
        i_read_flag  = '0;
        cyc          = 0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        full_pulses  = 0;
        start_cyc    = 0;
        cap_idx      = 0;
        lfsr         = 8'd74;
        post_reset   = 1'b0;
        count_chk    = 1'b0;
        frozen_chk   = 1'b0;
        wave_chk     = 1'b0;
        cap_cmp      = 1'b0;
        exp_cap      = '0;
        exp_sts      = '0;

        repeat (2) @(posedge i_clk);
        #5;
        i_rst_n    = 1'b1;
        post_reset = 1'b1;
        next_cycles(1);
        post_reset = 1'b0;

        // start from ext a, count, stop, clear.
        i_ext_din_a = 1'b1;
        start_cyc   = cyc;
        wait_count(W'(1));
        a_start_latency: assert (cyc == start_cyc + 4) else begin
            fail_cnt = fail_cnt + 1;
            $display("count left 0 after %0d cycles instead of 4", cyc - start_cyc);
        end
        count_chk = 1'b1;
        next_cycles(8);
        count_chk = 1'b0;
        soft_strobe(1'b0, 1'b1, 1'b0);
        next_cycles(1);
        frozen_chk = 1'b1;
        next_cycles(4);
        frozen_chk = 1'b0;
        soft_strobe(1'b0, 1'b0, 1'b1);

        // waveform, restart at t2.
        pick_targets(1'b0);
        i_mode = timer_cfg_pkg::WAVEFORM;
        soft_strobe(1'b1, 1'b0, 1'b0);
        next_cycles(1);
        wave_chk = 1'b1;
        next_cycles(3 * (int'(i_wave_a.t2) + 1));
        wave_chk = 1'b0;
        soft_strobe(1'b0, 1'b1, 1'b0);
        soft_strobe(1'b0, 1'b0, 1'b1);

        // waveform, halt at t2.
        pick_targets(1'b1);
        soft_strobe(1'b1, 1'b0, 1'b0);
        next_cycles(1);
        wave_chk = 1'b1;
        next_cycles(int'(i_wave_a.t2) + 8);
        wave_chk = 1'b0;
        soft_strobe(1'b0, 1'b1, 1'b0);

        // capture on ext b, discard then overwrite.
        i_mode = timer_cfg_pkg::CAPTURE;
        soft_strobe(1'b0, 1'b0, 1'b1);
        start_cyc = cyc;
        soft_strobe(1'b1, 1'b0, 1'b0);
        repeat (N + 1) capture_edge();
        i_cap_cfg.ovw_a = '1;
        repeat (N) capture_edge();

        // read flag on a1 only.
        i_read_flag.a[1] = 1'b1;
        next_cycles(1);
        i_read_flag = '0;
        exp_sts[1]  = 1'b0;
        next_cycles(1);
        compare_capture();

        soft_strobe(1'b0, 1'b0, 1'b1);
        exp_cap = '0;
        exp_sts = '0;
        next_cycles(1);
        compare_capture();
        soft_strobe(1'b0, 1'b1, 1'b0);
        next_cycles(2);

        a_full_once: assert (full_pulses == 1) else begin
            fail_cnt = fail_cnt + 1;
            $display("cap_a_full pulsed %0d times instead of once", full_pulses);
        end
        print_counts();
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verilog/capture_bank.sv
`timescale 1ns/1ps
`include "timer_settings.svh"

module capture_bank (
    input  logic                                          i_clk,
    input  logic                                          i_rst_n,
    input  logic                                          i_enable,
    input  logic                                          i_soft_clear,
    input  timer_evt_pkg::evt_t                           i_evt,
    input  timer_cfg_pkg::mode_t                          i_mode,
    input  logic [`TMR_COUNT_W-1:0]                       i_count,
    input  timer_cfg_pkg::cap_cfg_t                       i_cap_cfg,
    input  timer_evt_pkg::cap_status_t                    i_read_flag,
    output logic [`TMR_CAP_N-1:0][`TMR_COUNT_W-1:0]       o_cap_a,
    output logic [`TMR_CAP_N-1:0][`TMR_COUNT_W-1:0]       o_cap_b,
    output timer_evt_pkg::cap_status_t                    o_cap_status
);

    localparam int N     = `TMR_CAP_N;
    localparam int W     = `TMR_COUNT_W;
    localparam int IDX_W = $clog2(N);

    logic                     cap_en;
    logic [1:0]               din_v;
    logic [1:0][N-1:0]        ovw_v;
    logic [1:0][N-1:0]        rd_v;
    logic [1:0][N-1:0]        sts_q;
    logic [1:0][N-1:0][W-1:0] cap_q;

    // channel 0 is a, channel 1 is b.
    assign din_v = {i_evt.din1, i_evt.din0};
    assign ovw_v = {i_cap_cfg.ovw_b, i_cap_cfg.ovw_a};
    assign rd_v  = {i_read_flag.b, i_read_flag.a};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cap_en <= 1'b0;
        end else if (!i_enable || i_evt.stop) begin
            cap_en <= 1'b0;
        end else if (i_evt.start) begin
            cap_en <= (i_mode == timer_cfg_pkg::CAPTURE);
        end
    end

    for (genvar ch = 0; ch < 2; ch++) begin : g_chan
        logic [IDX_W-1:0]  idx;  // next slot, round robin.
        logic [N-1:0]      sts;
        logic [N-1:0][W-1:0] cap;

        always_ff @(posedge i_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                idx <= '0;
                sts <= '0;
                cap <= '0;
            end else if (!i_enable || i_soft_clear) begin
                idx <= '0;
                sts <= '0;
                cap <= '0;
            end else if (cap_en && din_v[ch]) begin
                idx <= (idx == IDX_W'(N - 1)) ? '0 : idx + 1'b1;
                sts <= sts & ~rd_v[ch];
                if (!sts[idx] || ovw_v[ch][idx]) begin
                    cap[idx] <= i_count;
                    sts[idx] <= 1'b1;  // store wins over a read in the same cycle.
                end
            end else begin
                sts <= sts & ~rd_v[ch];
            end
        end

        assign cap_q[ch] = cap;
        assign sts_q[ch] = sts;

        a_idx_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
            idx < IDX_W'(N));
    end

    assign o_cap_a        = cap_q[0];
    assign o_cap_b        = cap_q[1];
    assign o_cap_status.a = sts_q[0];
    assign o_cap_status.b = sts_q[1];

endmodule

//--- verilog/count_core.sv
`timescale 1ns/1ps
`include "timer_settings.svh"

module count_core (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_enable,
    input  logic                       i_soft_clear,
    input  timer_evt_pkg::evt_t        i_evt,
    input  timer_cfg_pkg::mode_t       i_mode,
    input  timer_cfg_pkg::wave_chan_t  i_wave_a,
    input  timer_cfg_pkg::wave_chan_t  i_wave_b,
    output logic [`TMR_COUNT_W-1:0]    o_count,
    output logic                       o_run,
    output logic                       o_period_hit
);

    logic wave_run;
    logic hit_a;
    logic hit_b;
    logic restart;
    logic halt;

    // period targets only matter while running a waveform.
    assign wave_run = o_run && (i_mode == timer_cfg_pkg::WAVEFORM);
    assign hit_a    = wave_run && (o_count == i_wave_a.t2);
    assign hit_b    = wave_run && (o_count == i_wave_b.t2);

    assign restart      = (hit_a && !i_wave_a.halt) || (hit_b && !i_wave_b.halt);
    assign halt         = (hit_a && i_wave_a.halt) || (hit_b && i_wave_b.halt);
    assign o_period_hit = hit_a || hit_b;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_run <= 1'b0;
        end else if (!i_enable || i_evt.stop) begin
            o_run <= 1'b0;  // stop beats start.
        end else if (i_evt.start) begin
            o_run <= 1'b1;
        end else if (halt) begin
            o_run <= 1'b0;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_count <= '0;
        end else if (!i_enable || i_soft_clear) begin
            o_count <= '0;
        end else if (o_run) begin
            if (restart) begin
                o_count <= '0;
            end else if (!halt) begin
                o_count <= o_count + 1'b1;
            end
        end
    end

    a_idle_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !o_run && i_enable && !i_soft_clear |=> $stable(o_count));

endmodule

//--- verilog/event_select.sv
`timescale 1ns/1ps
`include "timer_settings.svh"

module event_select (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_ext_din_a,
    input  logic                     i_ext_din_b,
    input  logic [`TMR_INNER_N-1:0]  i_inner_din,
    input  logic                     i_soft_start,
    input  logic                     i_soft_stop,
    input  timer_cfg_pkg::src_cfg_t  i_src,
    output timer_evt_pkg::evt_t      o_evt
);

    localparam int SRC_N    = 1 << `TMR_SEL_W;
    localparam int EV_N     = 4;
    localparam int EV_START = 3;
    localparam int EV_STOP  = 2;
    localparam int EV_DIN0  = 1;
    localparam int EV_DIN1  = 0;

    logic [SRC_N-1:0]                  src_vec;
    timer_cfg_pkg::ev_src_t [EV_N-1:0] ev_cfg;
    logic [EV_N-1:0][1:0]              hist;  // [0] newest sample.
    logic [EV_N-1:0]                   edge_hit;
    logic [EV_N-1:0]                   flag_q;

    function automatic logic detect(input logic [1:0] code, input logic [1:0] h);
        case (code)
            `TMR_EDGE_RISE: return h[0] & ~h[1];
            `TMR_EDGE_FALL: return ~h[0] & h[1];
            `TMR_EDGE_BOTH: return h[0] ^ h[1];
            default:        return 1'b0;
        endcase
    endfunction

    // unused select codes read as constant low.
    assign src_vec = {{(SRC_N - 2 - `TMR_INNER_N){1'b0}}, i_inner_din, i_ext_din_b, i_ext_din_a};
    assign ev_cfg  = {i_src.start, i_src.stop, i_src.din0, i_src.din1};

    always_comb begin
        for (int k = 0; k < EV_N; k++) begin
            edge_hit[k] = detect(ev_cfg[k].edg, hist[k]);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hist   <= '0;
            flag_q <= '0;
        end else begin
            for (int k = 0; k < EV_N; k++) begin
                hist[k] <= {hist[k][0], src_vec[ev_cfg[k].sel]};
            end
            flag_q <= edge_hit;  // flag one cycle after the sample.
        end
    end

    assign o_evt.start = flag_q[EV_START] | i_soft_start;
    assign o_evt.stop  = flag_q[EV_STOP] | i_soft_stop;
    assign o_evt.din0  = flag_q[EV_DIN0];
    assign o_evt.din1  = flag_q[EV_DIN1];

    for (genvar k = 0; k < EV_N; k++) begin : g_chk
        a_none_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
            ev_cfg[k].edg == `TMR_EDGE_NONE |=> !flag_q[k]);
    end

endmodule

//--- verilog/irq_gen.sv
`timescale 1ns/1ps

module irq_gen (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  timer_evt_pkg::cap_status_t  i_cap_status,
    input  logic                        i_period_hit,
    output timer_evt_pkg::irq_t         o_irq
);

    logic [2:0] cond;
    logic [2:0] cond_q;

    // same bit order as irq_t.
    assign cond = {&i_cap_status.a, &i_cap_status.b, i_period_hit};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cond_q <= '0;
            o_irq  <= '0;
        end else begin
            cond_q <= cond;
            o_irq  <= timer_evt_pkg::irq_t'(cond & ~cond_q);  // rising edges only.
        end
    end

endmodule

//--- verilog/timer_cfg_pkg.sv
`include "timer_settings.svh"

package timer_cfg_pkg;

    // one event: where it comes from and which edge counts.
    typedef struct packed {
        logic [`TMR_SEL_W-1:0] sel;
        logic [1:0]            edg;
    } ev_src_t;

    typedef struct packed {
        ev_src_t start;
        ev_src_t stop;
        ev_src_t din0;
        ev_src_t din1;
    } src_cfg_t;

    // compare targets for one output pin.
    typedef struct packed {
        logic [`TMR_COUNT_W-1:0] t0;  // drive low.
        logic [`TMR_COUNT_W-1:0] t1;  // drive high.
        logic [`TMR_COUNT_W-1:0] t2;  // end of period.
        logic                    keep;  // hold level at t2.
        logic                    halt;  // stop counter at t2.
        logic                    idle_level;
    } wave_chan_t;

    // 1 overwrites a full register, 0 drops the new value.
    typedef struct packed {
        logic [`TMR_CAP_N-1:0] ovw_b;
        logic [`TMR_CAP_N-1:0] ovw_a;
    } cap_cfg_t;

    typedef enum logic {
        CAPTURE  = 1'b0,
        WAVEFORM = 1'b1
    } mode_t;

endpackage

//--- verilog/timer_evt_pkg.sv
`include "timer_settings.svh"

package timer_evt_pkg;

    // one-cycle event flags.
    typedef struct packed {
        logic start;
        logic stop;
        logic din0;
        logic din1;
    } evt_t;

    // status of the capture registers, a0..a2 in the low bits.
    typedef struct packed {
        logic [`TMR_CAP_N-1:0] b;
        logic [`TMR_CAP_N-1:0] a;
    } cap_status_t;

    // interrupt pulses.
    typedef struct packed {
        logic cap_a_full;
        logic cap_b_full;
        logic period_hit;
    } irq_t;

endpackage

//--- verilog/timer_settings.svh
`ifndef TIMER_SETTINGS_SVH
`define TIMER_SETTINGS_SVH

// counter and compare target width.
`define TMR_COUNT_W 32

// sibling counter inputs.
`define TMR_INNER_N 4

// source select: ext a, ext b, then the inner inputs.
`define TMR_SEL_W 3

// edge codes for the event sources.
`define TMR_EDGE_RISE 2'd0
`define TMR_EDGE_FALL 2'd1
`define TMR_EDGE_BOTH 2'd2
`define TMR_EDGE_NONE 2'd3

// capture registers per channel.
`define TMR_CAP_N 3

`endif

//--- verilog/timer_top.sv
`timescale 1ns/1ps
`include "timer_settings.svh"

module timer_top (
    input  logic                                     i_clk,
    input  logic                                     i_rst_n,
    input  logic                                     i_enable,
    input  logic                                     i_ext_din_a,
    input  logic                                     i_ext_din_b,
    input  logic [`TMR_INNER_N-1:0]                  i_inner_din,
    input  logic                                     i_soft_start,
    input  logic                                     i_soft_stop,
    input  logic                                     i_soft_clear,
    input  timer_cfg_pkg::mode_t                     i_mode,
    input  timer_cfg_pkg::src_cfg_t                  i_src,
    input  timer_cfg_pkg::wave_chan_t                i_wave_a,
    input  timer_cfg_pkg::wave_chan_t                i_wave_b,
    input  timer_cfg_pkg::cap_cfg_t                  i_cap_cfg,
    input  timer_evt_pkg::cap_status_t               i_read_flag,
    output logic                                     o_dout_a,
    output logic                                     o_dout_b,
    output logic                                     o_dout_a_oen,
    output logic                                     o_dout_b_oen,
    output logic [`TMR_COUNT_W-1:0]                  o_count,
    output logic [`TMR_CAP_N-1:0][`TMR_COUNT_W-1:0]  o_cap_a,
    output logic [`TMR_CAP_N-1:0][`TMR_COUNT_W-1:0]  o_cap_b,
    output timer_evt_pkg::cap_status_t               o_cap_status,
    output timer_evt_pkg::irq_t                      o_irq
);

    timer_evt_pkg::evt_t evt;
    logic                period_hit;

    event_select event_select_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_ext_din_a  (i_ext_din_a),
        .i_ext_din_b  (i_ext_din_b),
        .i_inner_din  (i_inner_din),
        .i_soft_start (i_soft_start),
        .i_soft_stop  (i_soft_stop),
        .i_src        (i_src),
        .o_evt        (evt)
    );

    count_core count_core_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_enable     (i_enable),
        .i_soft_clear (i_soft_clear),
        .i_evt        (evt),
        .i_mode       (i_mode),
        .i_wave_a     (i_wave_a),
        .i_wave_b     (i_wave_b),
        .o_count      (o_count),
        .o_run        (),
        .o_period_hit (period_hit)
    );

    waveform_gen waveform_gen_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_enable     (i_enable),
        .i_evt        (evt),
        .i_mode       (i_mode),
        .i_count      (o_count),
        .i_wave_a     (i_wave_a),
        .i_wave_b     (i_wave_b),
        .o_dout_a     (o_dout_a),
        .o_dout_b     (o_dout_b),
        .o_dout_a_oen (o_dout_a_oen),
        .o_dout_b_oen (o_dout_b_oen)
    );

    capture_bank capture_bank_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_enable     (i_enable),
        .i_soft_clear (i_soft_clear),
        .i_evt        (evt),
        .i_mode       (i_mode),
        .i_count      (o_count),
        .i_cap_cfg    (i_cap_cfg),
        .i_read_flag  (i_read_flag),
        .o_cap_a      (o_cap_a),
        .o_cap_b      (o_cap_b),
        .o_cap_status (o_cap_status)
    );

    irq_gen irq_gen_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cap_status (o_cap_status),
        .i_period_hit (period_hit),
        .o_irq        (o_irq)
    );

endmodule

//--- verilog/waveform_gen.sv
`timescale 1ns/1ps
`include "timer_settings.svh"

module waveform_gen (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_enable,
    input  timer_evt_pkg::evt_t        i_evt,
    input  timer_cfg_pkg::mode_t       i_mode,
    input  logic [`TMR_COUNT_W-1:0]    i_count,
    input  timer_cfg_pkg::wave_chan_t  i_wave_a,
    input  timer_cfg_pkg::wave_chan_t  i_wave_b,
    output logic                       o_dout_a,
    output logic                       o_dout_b,
    output logic                       o_dout_a_oen,
    output logic                       o_dout_b_oen
);

    logic pins_on;
    logic wave_mode;

    // next pin level from the compare targets.
    function automatic logic next_level(input timer_cfg_pkg::wave_chan_t w,
                                        input logic [`TMR_COUNT_W-1:0] cnt,
                                        input logic cur);
        logic lvl;
        lvl = cur;
        if (cnt == w.t0) begin
            lvl = 1'b0;
        end else if (cnt == w.t1) begin
            lvl = 1'b1;
        end else if (cnt == w.t2 && !w.keep) begin
            lvl = w.idle_level;
        end
        return lvl;
    endfunction

    assign wave_mode = (i_mode == timer_cfg_pkg::WAVEFORM);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pins_on  <= 1'b0;
            o_dout_a <= 1'b0;
            o_dout_b <= 1'b0;
        end else if (!i_enable || i_evt.stop) begin
            pins_on <= 1'b0;
        end else if (i_evt.start) begin
            pins_on <= wave_mode;  // capture start releases the pins.
            if (wave_mode) begin
                o_dout_a <= i_wave_a.idle_level;
                o_dout_b <= i_wave_b.idle_level;
            end
        end else if (pins_on) begin
            o_dout_a <= next_level(i_wave_a, i_count, o_dout_a);
            o_dout_b <= next_level(i_wave_b, i_count, o_dout_b);
        end
    end

    assign o_dout_a_oen = ~pins_on;  // active low.
    assign o_dout_b_oen = ~pins_on;

    a_oen_mode: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !o_dout_a_oen |-> i_mode == timer_cfg_pkg::WAVEFORM);

endmodule
